//--- hdl/conv_params_pkg.sv
package conv_params_pkg;

    localparam int DATA_WIDTH  = 16;
    localparam int ACC_WIDTH   = 40;
    localparam int MAC_LATENCY = 2;     // Product stage, then sum stage.

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

    localparam acc_t data_max = acc_t'(2 ** (DATA_WIDTH - 1) - 1);

    function automatic int out_size(int ifm_size, int kernel_size);
        return ifm_size - kernel_size + 1;
    endfunction

    // Span from the oldest to the newest pixel of one window.
    function automatic int fifo_len(int ifm_size, int kernel_size);
        return (kernel_size - 1) * ifm_size + kernel_size;
    endfunction

    // Index and address width that stays legal for a count of one.
    function automatic int idx_width(int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

endpackage

//--- hdl/conv_ctrl_pkg.sv
package conv_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN,       // Reads done, waiting for the MAC pipeline to empty.
        HOLD         // Map complete, next layer not yet started.
    } layer_state_t;

    typedef enum logic {
        WAIT_FILL,
        WAIT_NEXT
    } handoff_state_t;

endpackage

//--- hdl/conv_control_unit.sv
`timescale 1ns/1ps

module conv_control_unit
    import conv_params_pkg::*;
    import conv_ctrl_pkg::*;
#(
    parameter int IFM_SIZE          = 5,
    parameter int IFM_DEPTH         = 4,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2,
    parameter int NUMBER_OF_UNITS   = 2
)(
    input  logic clk,
    input  logic reset,
    input  logic start_from_previous,
    input  logic end_from_next,
    input  logic fill_tick,
    output logic ready,
    output logic end_to_previous,
    output logic ifm_read_enable,
    output logic [idx_width(IFM_SIZE*IFM_SIZE)-1:0] ifm_read_address,
    output logic shift_enable,
    output logic window_valid,
    output logic [idx_width(NUMBER_OF_FILTERS)-1:0] filter_index,
    output logic [idx_width(IFM_DEPTH/NUMBER_OF_UNITS)-1:0] pass_index,
    output logic first_pass,
    output logic last_pass,
    output logic start_to_next,
    output logic ofm_bank_sel
);

    localparam int PASSES  = IFM_DEPTH / NUMBER_OF_UNITS;
    localparam int PIXELS  = IFM_SIZE * IFM_SIZE;
    localparam int RC_W    = idx_width(IFM_SIZE);
    localparam int DRAIN_W = idx_width(MAC_LATENCY + 2);

    layer_state_t   state, state_next;
    handoff_state_t hand_state;
    logic [RC_W-1:0]    row_cnt, col_cnt;
    logic [DRAIN_W-1:0] drain_cnt;
    logic last_pixel, drain_done, last_filter;

    assign last_pixel      = (ifm_read_address == PIXELS - 1);
    assign drain_done      = (state == DRAIN) && (drain_cnt == MAC_LATENCY + 1);
    assign last_filter     = (filter_index == NUMBER_OF_FILTERS - 1);
    assign first_pass      = (pass_index == 0);
    assign last_pass       = (pass_index == PASSES - 1);
    assign ready           = (state == IDLE);
    assign end_to_previous = (state != READ);
    assign ifm_read_enable = (state == READ);

    // ======================================================================
    // Layer sequencer
    // ======================================================================
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (start_from_previous)
                    state_next = READ;
            READ:
                if (last_pixel)
                    state_next = DRAIN;
            DRAIN:
                if (drain_done)
                begin
                    if (last_pass && !start_to_next)
                        state_next = HOLD;         // Next layer is still busy.
                    else if (last_pass && last_filter)
                        state_next = IDLE;
                    else
                        state_next = READ;
                end
            HOLD:
                if (start_to_next)
                    state_next = (filter_index == 0) ? IDLE : READ;
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ifm_read_address <= '0;
            row_cnt          <= '0;
            col_cnt          <= '0;
        end
        else if (ifm_read_enable)
        begin
            ifm_read_address <= last_pixel ? '0 : ifm_read_address + 1'b1;
            if (col_cnt == IFM_SIZE - 1)
            begin
                col_cnt <= '0;
                row_cnt <= (row_cnt == IFM_SIZE - 1) ? '0 : row_cnt + 1'b1;
            end
            else
                col_cnt <= col_cnt + 1'b1;
        end
    end

    // Read data arrives one cycle after its address.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            shift_enable <= 1'b0;
            window_valid <= 1'b0;
        end
        else
        begin
            shift_enable <= ifm_read_enable;
            window_valid <= ifm_read_enable && (row_cnt >= KERNEL_SIZE - 1)
                            && (col_cnt >= KERNEL_SIZE - 1);
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            drain_cnt <= '0;
        else if ((state == DRAIN) && !drain_done)
            drain_cnt <= drain_cnt + 1'b1;
        else
            drain_cnt <= '0;
    end

    // Passes and filters advance as the drain ends, after the last write.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pass_index   <= '0;
            filter_index <= '0;
        end
        else if (drain_done)
        begin
            if (last_pass)
            begin
                pass_index   <= '0;
                filter_index <= last_filter ? '0 : filter_index + 1'b1;
            end
            else
                pass_index <= pass_index + 1'b1;
        end
    end

    // ======================================================================
    // Hand-off to the next layer
    // ======================================================================
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            hand_state <= WAIT_FILL;
        else if (hand_state == WAIT_FILL)
        begin
            if (fill_tick && !end_from_next)
                hand_state <= WAIT_NEXT;
        end
        else if (end_from_next)
            hand_state <= WAIT_FILL;
    end

    assign start_to_next = (hand_state == WAIT_FILL) ? (fill_tick && end_from_next)
                                                     : end_from_next;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ofm_bank_sel <= 1'b0;
        else if (start_to_next)
            ofm_bank_sel <= ~ofm_bank_sel;
    end

    a_pass_range: assert property (@(posedge clk) disable iff (reset)
        pass_index < PASSES);

    // The last output write lands in the final drain cycle of a last pass.
    a_fill_in_drain: assert property (@(posedge clk) disable iff (reset)
        fill_tick |-> (drain_done && last_pass));

    a_hold_pending: assert property (@(posedge clk) disable iff (reset)
        (state == HOLD) |-> (hand_state == WAIT_NEXT));

endmodule

//--- hdl/window_feeder.sv
`timescale 1ns/1ps

module window_feeder
    import conv_params_pkg::*;
#(
    parameter int IFM_SIZE        = 5,
    parameter int KERNEL_SIZE     = 3,
    parameter int NUMBER_OF_UNITS = 2
)(
    input  logic clk,
    input  logic reset,
    input  logic shift_enable,
    input  logic [NUMBER_OF_UNITS*DATA_WIDTH-1:0] ifm_read_data,
    output logic [NUMBER_OF_UNITS*KERNEL_SIZE*KERNEL_SIZE*DATA_WIDTH-1:0] window_data
);

    localparam int FIFO_LEN = fifo_len(IFM_SIZE, KERNEL_SIZE);
    localparam int KK       = KERNEL_SIZE * KERNEL_SIZE;

    for (genvar u = 0; u < NUMBER_OF_UNITS; u++)
    begin : g_unit
        data_t pixel_in;
        data_t line_buf [FIFO_LEN-1];   // The arriving pixel is word 0 of the line.

        assign pixel_in = ifm_read_data[u*DATA_WIDTH +: DATA_WIDTH];

        always_ff @(posedge clk or posedge reset)
        begin
            if (reset)
            begin
                for (int i = 0; i < FIFO_LEN - 1; i++)
                    line_buf[i] <= '0;
            end
            else if (shift_enable)
            begin
                line_buf[0] <= pixel_in;
                for (int i = 1; i < FIFO_LEN - 1; i++)
                    line_buf[i] <= line_buf[i-1];
            end
        end

        // Tap r*K+c sits (K-1-r) rows and (K-1-c) pixels behind the newest one.
        for (genvar r = 0; r < KERNEL_SIZE; r++)
        begin : g_row
            for (genvar c = 0; c < KERNEL_SIZE; c++)
            begin : g_col
                localparam int DIST = (KERNEL_SIZE - 1 - r) * IFM_SIZE + (KERNEL_SIZE - 1 - c);
                localparam int TAP  = u * KK + r * KERNEL_SIZE + c;
                if (DIST == 0)
                begin : g_new
                    assign window_data[TAP*DATA_WIDTH +: DATA_WIDTH] = pixel_in;
                end
                else
                begin : g_old
                    assign window_data[TAP*DATA_WIDTH +: DATA_WIDTH] = line_buf[DIST-1];
                end
            end
        end
    end

endmodule

//--- hdl/mac_unit.sv
`timescale 1ns/1ps

module mac_unit
    import conv_params_pkg::*;
#(
    parameter int KERNEL_SIZE = 3
)(
    input  logic clk,
    input  logic reset,
    input  logic window_valid,
    input  logic [KERNEL_SIZE*KERNEL_SIZE*DATA_WIDTH-1:0] window,
    input  logic [KERNEL_SIZE*KERNEL_SIZE*DATA_WIDTH-1:0] kernel,
    output acc_t unit_sum,
    output logic unit_valid
);

    localparam int KK = KERNEL_SIZE * KERNEL_SIZE;

    acc_t product [KK];
    acc_t product_sum;
    logic [MAC_LATENCY-1:0] valid_pipe;

    always_ff @(posedge clk)
    begin
        if (window_valid)
        begin
            for (int t = 0; t < KK; t++)
                product[t] <= data_t'(window[t*DATA_WIDTH +: DATA_WIDTH])
                              * data_t'(kernel[t*DATA_WIDTH +: DATA_WIDTH]);
        end
        unit_sum <= product_sum;
    end

    always_comb
    begin
        product_sum = '0;
        for (int t = 0; t < KK; t++)
            product_sum = product_sum + product[t];
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            valid_pipe <= '0;
        else
        begin
            valid_pipe[0] <= window_valid;
            for (int s = 1; s < MAC_LATENCY; s++)
                valid_pipe[s] <= valid_pipe[s-1];
        end
    end

    assign unit_valid = valid_pipe[MAC_LATENCY-1];

    // A valid result never carries unknown bits from the window or kernel.
    a_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(unit_valid) && (!unit_valid || !$isunknown(unit_sum)));

endmodule

//--- hdl/psum_accumulator.sv
`timescale 1ns/1ps

module psum_accumulator
    import conv_params_pkg::*;
#(
    parameter int IFM_SIZE          = 5,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_UNITS   = 2,
    parameter int NUMBER_OF_FILTERS = 2
)(
    input  logic clk,
    input  logic reset,
    input  logic unit_valid,
    input  logic [NUMBER_OF_UNITS*ACC_WIDTH-1:0] unit_sum,
    input  data_t bias,
    input  logic first_pass,
    input  logic last_pass,
    input  logic [idx_width(NUMBER_OF_FILTERS)-1:0] filter_index,
    output logic ofm_write_enable,
    output logic [idx_width(out_size(IFM_SIZE, KERNEL_SIZE)
                            * out_size(IFM_SIZE, KERNEL_SIZE))-1:0] ofm_write_address,
    output data_t ofm_write_data,
    output logic [idx_width(NUMBER_OF_FILTERS)-1:0] ofm_filter,
    output logic fill_tick
);

    localparam int OUT_PIXELS = out_size(IFM_SIZE, KERNEL_SIZE) * out_size(IFM_SIZE, KERNEL_SIZE);

    acc_t psum_buf [OUT_PIXELS];
    logic [idx_width(OUT_PIXELS)-1:0] psum_idx;
    acc_t unit_total, new_sum;

    function automatic data_t relu_sat(acc_t value);
        if (value < 0)
            return '0;
        if (value > data_max)
            return data_t'(data_max);
        return value[DATA_WIDTH-1:0];
    endfunction

    always_comb
    begin
        unit_total = '0;
        for (int u = 0; u < NUMBER_OF_UNITS; u++)
            unit_total = unit_total + acc_t'(unit_sum[u*ACC_WIDTH +: ACC_WIDTH]);
        new_sum = first_pass ? unit_total + acc_t'(bias) : psum_buf[psum_idx] + unit_total;
    end

    always_ff @(posedge clk)
    begin
        if (unit_valid && !last_pass)
            psum_buf[psum_idx] <= new_sum;
        if (unit_valid)
        begin
            ofm_write_address <= psum_idx;
            ofm_write_data    <= relu_sat(new_sum);
            ofm_filter        <= filter_index;
        end
    end

    // One index step per window; the index wraps at the end of every pass.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            psum_idx         <= '0;
            ofm_write_enable <= 1'b0;
            fill_tick        <= 1'b0;
        end
        else
        begin
            ofm_write_enable <= unit_valid && last_pass;
            fill_tick        <= unit_valid && last_pass && (psum_idx == OUT_PIXELS - 1);
            if (unit_valid)
                psum_idx <= (psum_idx == OUT_PIXELS - 1) ? '0 : psum_idx + 1'b1;
        end
    end

endmodule

//--- hdl/weight_bank.sv
`timescale 1ns/1ps

module weight_bank
    import conv_params_pkg::*;
#(
    parameter int KERNEL_SIZE       = 3,
    parameter int IFM_DEPTH         = 4,
    parameter int NUMBER_OF_FILTERS = 2,
    parameter int NUMBER_OF_UNITS   = 2
)(
    input  logic clk,
    input  logic wm_write_enable,
    input  logic [idx_width(NUMBER_OF_FILTERS*IFM_DEPTH*KERNEL_SIZE*KERNEL_SIZE)-1:0]
                 wm_write_address,
    input  data_t wm_write_data,
    input  logic bm_write_enable,
    input  logic [idx_width(NUMBER_OF_FILTERS)-1:0] filter_index,
    input  logic [idx_width(IFM_DEPTH/NUMBER_OF_UNITS)-1:0] pass_index,
    output logic [NUMBER_OF_UNITS*KERNEL_SIZE*KERNEL_SIZE*DATA_WIDTH-1:0] kernels,
    output data_t bias
);

    localparam int KK       = KERNEL_SIZE * KERNEL_SIZE;
    localparam int WM_DEPTH = NUMBER_OF_FILTERS * IFM_DEPTH * KK;

    data_t weight_mem [WM_DEPTH];       // Filter, then channel, then tap.
    data_t bias_mem   [NUMBER_OF_FILTERS];

    always_ff @(posedge clk)
    begin
        if (wm_write_enable)
            weight_mem[wm_write_address] <= wm_write_data;
        if (bm_write_enable)
            bias_mem[wm_write_address[idx_width(NUMBER_OF_FILTERS)-1:0]] <= wm_write_data;
    end

    always_comb
    begin
        for (int u = 0; u < NUMBER_OF_UNITS; u++)
            for (int t = 0; t < KK; t++)
                kernels[(u*KK+t)*DATA_WIDTH +: DATA_WIDTH] = weight_mem[
                    (filter_index * IFM_DEPTH + pass_index * NUMBER_OF_UNITS + u) * KK + t];
    end

    assign bias = bias_mem[filter_index];

endmodule

//--- hdl/conv_layer_top.sv
`timescale 1ns/1ps

module conv_layer_top
    import conv_params_pkg::*;
#(
    parameter int IFM_SIZE          = 5,
    parameter int IFM_DEPTH         = 4,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2,
    parameter int NUMBER_OF_UNITS   = 2
)(
    input  logic clk,
    input  logic reset,
    input  logic start_from_previous,
    output logic ready,
    output logic end_to_previous,
    output logic ifm_read_enable,
    output logic [idx_width(IFM_SIZE*IFM_SIZE)-1:0] ifm_read_address,
    input  logic [NUMBER_OF_UNITS*DATA_WIDTH-1:0] ifm_read_data,
    output logic [idx_width(IFM_DEPTH/NUMBER_OF_UNITS)-1:0] ifm_pass,
    input  logic wm_write_enable,
    input  logic [idx_width(NUMBER_OF_FILTERS*IFM_DEPTH*KERNEL_SIZE*KERNEL_SIZE)-1:0]
                 wm_write_address,
    input  data_t wm_write_data,
    input  logic bm_write_enable,
    output logic ofm_write_enable,
    output logic [idx_width(out_size(IFM_SIZE, KERNEL_SIZE)
                            * out_size(IFM_SIZE, KERNEL_SIZE))-1:0] ofm_write_address,
    output data_t ofm_write_data,
    output logic [idx_width(NUMBER_OF_FILTERS)-1:0] ofm_filter,
    input  logic end_from_next,
    output logic start_to_next,
    output logic ofm_bank_sel
);

    localparam int KK = KERNEL_SIZE * KERNEL_SIZE;

    logic shift_enable, window_valid, first_pass, last_pass, fill_tick;
    logic [idx_width(NUMBER_OF_FILTERS)-1:0] filter_index;
    logic [NUMBER_OF_UNITS*KK*DATA_WIDTH-1:0] window_data, kernels;
    logic [NUMBER_OF_UNITS*ACC_WIDTH-1:0] unit_sum;
    logic [NUMBER_OF_UNITS-1:0] unit_valid;
    data_t bias;

    conv_control_unit #(
        .IFM_SIZE(IFM_SIZE), .IFM_DEPTH(IFM_DEPTH), .KERNEL_SIZE(KERNEL_SIZE),
        .NUMBER_OF_FILTERS(NUMBER_OF_FILTERS), .NUMBER_OF_UNITS(NUMBER_OF_UNITS)
    ) u_control (
        .clk(clk), .reset(reset), .start_from_previous(start_from_previous),
        .end_from_next(end_from_next), .fill_tick(fill_tick), .ready(ready),
        .end_to_previous(end_to_previous), .ifm_read_enable(ifm_read_enable),
        .ifm_read_address(ifm_read_address), .shift_enable(shift_enable),
        .window_valid(window_valid), .filter_index(filter_index), .pass_index(ifm_pass),
        .first_pass(first_pass), .last_pass(last_pass), .start_to_next(start_to_next),
        .ofm_bank_sel(ofm_bank_sel)
    );

    window_feeder #(
        .IFM_SIZE(IFM_SIZE), .KERNEL_SIZE(KERNEL_SIZE), .NUMBER_OF_UNITS(NUMBER_OF_UNITS)
    ) u_feeder (
        .clk(clk), .reset(reset), .shift_enable(shift_enable),
        .ifm_read_data(ifm_read_data), .window_data(window_data)
    );

    for (genvar u = 0; u < NUMBER_OF_UNITS; u++)
    begin : g_mac
        mac_unit #(.KERNEL_SIZE(KERNEL_SIZE)) u_mac (
            .clk(clk), .reset(reset), .window_valid(window_valid),
            .window(window_data[u*KK*DATA_WIDTH +: KK*DATA_WIDTH]),
            .kernel(kernels[u*KK*DATA_WIDTH +: KK*DATA_WIDTH]),
            .unit_sum(unit_sum[u*ACC_WIDTH +: ACC_WIDTH]), .unit_valid(unit_valid[u])
        );
    end

    psum_accumulator #(
        .IFM_SIZE(IFM_SIZE), .KERNEL_SIZE(KERNEL_SIZE),
        .NUMBER_OF_UNITS(NUMBER_OF_UNITS), .NUMBER_OF_FILTERS(NUMBER_OF_FILTERS)
    ) u_accumulator (
        .clk(clk), .reset(reset), .unit_valid(&unit_valid), .unit_sum(unit_sum),
        .bias(bias), .first_pass(first_pass), .last_pass(last_pass),
        .filter_index(filter_index), .ofm_write_enable(ofm_write_enable),
        .ofm_write_address(ofm_write_address), .ofm_write_data(ofm_write_data),
        .ofm_filter(ofm_filter), .fill_tick(fill_tick)
    );

    weight_bank #(
        .KERNEL_SIZE(KERNEL_SIZE), .IFM_DEPTH(IFM_DEPTH),
        .NUMBER_OF_FILTERS(NUMBER_OF_FILTERS), .NUMBER_OF_UNITS(NUMBER_OF_UNITS)
    ) u_weights (
        .clk(clk), .wm_write_enable(wm_write_enable), .wm_write_address(wm_write_address),
        .wm_write_data(wm_write_data), .bm_write_enable(bm_write_enable),
        .filter_index(filter_index), .pass_index(ifm_pass), .kernels(kernels), .bias(bias)
    );

endmodule

//--- bench/conv_model.svh
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// Expected output writes, oldest first.
int    exp_filter  [$];
int    exp_address [$];
data_t exp_value   [$];

// ReLU, then clip at the top of the signed data range.
function automatic data_t relu_clip(longint total);
    longint ceiling;
    ceiling = (longint'(1) << (DATA_WIDTH - 1)) - 1;
    if (total < 0)
        return '0;
    else if (total > ceiling)
        return data_t'(ceiling);
    else
        return data_t'(total);
endfunction

// Bias plus the window products over the full input depth.
function automatic longint window_total(int f, int oy, int ox);
    longint total;
    total = longint'(biases[f]);
    for (int ch = 0; ch < IFM_DEPTH; ch++)
        for (int r = 0; r < KERNEL_SIZE; r++)
            for (int c = 0; c < KERNEL_SIZE; c++)
                total += longint'(weights[(f * IFM_DEPTH + ch) * KK + r * KERNEL_SIZE + c])
                         * longint'(ifm_image[ch * PIXELS + (oy + r) * IFM_SIZE + ox + c]);
    return total;
endfunction

// One write per output pixel: filter by filter, rows top to bottom.
task automatic build_expected();
    exp_filter.delete();
    exp_address.delete();
    exp_value.delete();
    for (int f = 0; f < NUMBER_OF_FILTERS; f++)
        for (int oy = 0; oy < OUT_SIZE; oy++)
            for (int ox = 0; ox < OUT_SIZE; ox++)
            begin
                exp_filter.push_back(f);
                exp_address.push_back(oy * OUT_SIZE + ox);
                exp_value.push_back(relu_clip(window_total(f, oy, ox)));
            end
endtask

`endif

//--- bench/conv_layer_tb.sv
`timescale 1ns/1ps

module conv_layer_tb
    import conv_params_pkg::*;
();

    localparam int IFM_SIZE          = 5;
    localparam int IFM_DEPTH         = 4;
    localparam int KERNEL_SIZE       = 3;
    localparam int NUMBER_OF_FILTERS = 2;
    localparam int NUMBER_OF_UNITS   = 2;

    localparam int KK         = KERNEL_SIZE * KERNEL_SIZE;
    localparam int PIXELS     = IFM_SIZE * IFM_SIZE;
    localparam int PASSES     = IFM_DEPTH / NUMBER_OF_UNITS;
    localparam int OUT_SIZE   = IFM_SIZE - KERNEL_SIZE + 1;
    localparam int OUT_PIXELS = OUT_SIZE * OUT_SIZE;
    localparam int WM_DEPTH   = NUMBER_OF_FILTERS * IFM_DEPTH * KK;

    localparam int NUM_RUNS        = 5;
    localparam int RESET_CYCLES    = 10;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * NUMBER_OF_FILTERS * PASSES * (PIXELS + 20) * 4;

    localparam int MODE_PLAIN    = 0;
    localparam int MODE_NEG_BIAS = 1;    // Every output clamps to zero.
    localparam int MODE_LARGE    = 2;    // Every output saturates.

    typedef logic [idx_width(OUT_PIXELS)-1:0]        ofm_addr_t;
    typedef logic [idx_width(NUMBER_OF_FILTERS)-1:0] filter_t;

    logic clk, reset;
    logic start_from_previous, ready, end_to_previous;
    logic ifm_read_enable;
    logic [idx_width(PIXELS)-1:0] ifm_read_address;
    logic [NUMBER_OF_UNITS*DATA_WIDTH-1:0] ifm_read_data;
    logic [idx_width(PASSES)-1:0] ifm_pass;
    logic wm_write_enable, bm_write_enable;
    logic [idx_width(WM_DEPTH)-1:0] wm_write_address;
    data_t wm_write_data;
    logic ofm_write_enable;
    ofm_addr_t ofm_write_address;
    data_t ofm_write_data;
    filter_t ofm_filter;
    logic end_from_next, start_to_next, ofm_bank_sel;

    data_t ifm_image [IFM_DEPTH*PIXELS];
    data_t weights   [WM_DEPTH];
    data_t biases    [NUMBER_OF_FILTERS];
    logic [NUMBER_OF_UNITS*DATA_WIDTH-1:0] staged_read;
    int writes_seen [NUMBER_OF_FILTERS];
    int pending_maps, handoffs;
    logic exp_bank;

    `include "conv_model.svh"

    conv_layer_top #(
        .IFM_SIZE(IFM_SIZE), .IFM_DEPTH(IFM_DEPTH), .KERNEL_SIZE(KERNEL_SIZE),
        .NUMBER_OF_FILTERS(NUMBER_OF_FILTERS), .NUMBER_OF_UNITS(NUMBER_OF_UNITS)
    ) u_dut (
        .clk(clk), .reset(reset), .start_from_previous(start_from_previous),
        .ready(ready), .end_to_previous(end_to_previous),
        .ifm_read_enable(ifm_read_enable), .ifm_read_address(ifm_read_address),
        .ifm_read_data(ifm_read_data), .ifm_pass(ifm_pass),
        .wm_write_enable(wm_write_enable), .wm_write_address(wm_write_address),
        .wm_write_data(wm_write_data), .bm_write_enable(bm_write_enable),
        .ofm_write_enable(ofm_write_enable), .ofm_write_address(ofm_write_address),
        .ofm_write_data(ofm_write_data), .ofm_filter(ofm_filter),
        .end_from_next(end_from_next), .start_to_next(start_to_next),
        .ofm_bank_sel(ofm_bank_sel)
    );

    always #2 clk = ~clk;

    // ======================================================================
    // Error reporting and compare tasks
    // ======================================================================
    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic report_failure(string what);
        $display("ERROR at %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_data(string name, data_t actual, data_t expected);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_address(string name, ofm_addr_t actual, ofm_addr_t expected);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_index(string name, filter_t actual, filter_t expected);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_count(string name, int actual, int expected);
        if (actual != expected)
        begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // ======================================================================
    // Neighbouring layers and the output monitor
    // ======================================================================
    always @(negedge clk)
    begin
        ifm_read_data = staged_read;    // The address of the previous cycle.
        if (ifm_read_enable)
            for (int u = 0; u < NUMBER_OF_UNITS; u++)
                staged_read[u*DATA_WIDTH +: DATA_WIDTH] =
                    ifm_image[(int'(ifm_pass) * NUMBER_OF_UNITS + u) * PIXELS
                              + int'(ifm_read_address)];
    end

    task automatic take_write();
        if (exp_value.size() == 0)
            report_failure("the layer wrote an output with no write left to expect");
        else
        begin
            check_index("ofm_filter", ofm_filter, filter_t'(exp_filter[0]));
            check_address("ofm_write_address", ofm_write_address, ofm_addr_t'(exp_address[0]));
            check_data("ofm_write_data", ofm_write_data, exp_value[0]);
            writes_seen[exp_filter[0]]++;
            if (writes_seen[exp_filter[0]] == OUT_PIXELS)
                pending_maps++;
            void'(exp_filter.pop_front());
            void'(exp_address.pop_front());
            void'(exp_value.pop_front());
        end
    endtask

    always @(posedge clk)
    begin
        if (!reset)
        begin
            check_flag("ofm_bank_sel", ofm_bank_sel, exp_bank);
            if (ifm_read_enable && pending_maps > 0)
                report_failure("reading resumed while a finished map waited for hand-off");
            if (ofm_write_enable)
                take_write();
            if (start_to_next)
            begin
                if (!end_from_next)
                    report_failure("start_to_next rose while end_from_next was low");
                else if (pending_maps == 0)
                    report_failure("start_to_next came without a finished map");
                else
                begin
                    pending_maps--;
                    handoffs++;
                    exp_bank = ~exp_bank;
                end
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("the watchdog expired before the last run finished");
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    function automatic data_t random_word(int low, int high);
        int span;
        span = high - low + 1;
        return data_t'(low + int'($urandom % span));
    endfunction

    task automatic fill_layer_data(int mode);
        for (int i = 0; i < IFM_DEPTH * PIXELS; i++)
            ifm_image[i] = (mode == MODE_LARGE) ? random_word(1, 8) : random_word(-8, 7);
        for (int i = 0; i < WM_DEPTH; i++)
            weights[i] = (mode == MODE_LARGE) ? random_word(1000, 1800) : random_word(-8, 7);
        for (int f = 0; f < NUMBER_OF_FILTERS; f++)
            biases[f] = (mode == MODE_NEG_BIAS) ? random_word(-30000, -20000)
                                                : random_word(-64, 63);
    endtask

    task automatic load_weights();
        for (int a = 0; a < WM_DEPTH; a++)
        begin
            @(negedge clk);
            wm_write_enable  = 1'b1;
            wm_write_address = a;
            wm_write_data    = weights[a];
        end
        for (int f = 0; f < NUMBER_OF_FILTERS; f++)
        begin
            @(negedge clk);
            wm_write_enable  = 1'b0;
            bm_write_enable  = 1'b1;
            wm_write_address = f;
            wm_write_data    = biases[f];
        end
        @(negedge clk);
        bm_write_enable = 1'b0;
    endtask

    task automatic run_layer(int run);
        int mode;
        int pressure;
        mode     = (run == 3) ? MODE_NEG_BIAS : (run == 4) ? MODE_LARGE : MODE_PLAIN;
        pressure = (run == 0) ? 0 : (run == 1 || run == 4) ? 3 : 1;    // Quarters held low.
        fill_layer_data(mode);
        load_weights();
        build_expected();
        pending_maps = 0;
        handoffs     = 0;
        for (int f = 0; f < NUMBER_OF_FILTERS; f++)
            writes_seen[f] = 0;
        @(negedge clk);
        start_from_previous = 1'b1;
        do
        begin
            @(negedge clk);
            start_from_previous = 1'b0;
            end_from_next       = (($urandom % 4) >= pressure);
            if (!ready && ($urandom % 16 == 0))
                start_from_previous = 1'b1;    // Must be ignored mid-run.
        end
        while (handoffs < NUMBER_OF_FILTERS);
        end_from_next = 1'b1;
        check_flag("ready", ready, 1'b1);
        check_flag("end_to_previous", end_to_previous, 1'b1);
        repeat (8) @(negedge clk);
        check_count("outstanding expected writes", exp_value.size(), 0);
        for (int f = 0; f < NUMBER_OF_FILTERS; f++)
            check_count($sformatf("writes for filter %0d", f), writes_seen[f], OUT_PIXELS);
        check_count("start_to_next pulses", handoffs, NUMBER_OF_FILTERS);
    endtask

    initial
    begin
        void'($urandom(32'he5dd));
        clk                 = 1'b0;
        reset               = 1'b1;
        start_from_previous = 1'b0;
        end_from_next       = 1'b1;
        wm_write_enable     = 1'b0;
        bm_write_enable     = 1'b0;
        wm_write_address    = '0;
        wm_write_data       = '0;
        ifm_read_data       = '0;
        staged_read         = '0;
        exp_bank            = 1'b0;
        pending_maps        = 0;
        handoffs            = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_flag("ready", ready, 1'b1);
        check_flag("end_to_previous", end_to_previous, 1'b1);
        check_flag("ifm_read_enable", ifm_read_enable, 1'b0);
        check_flag("window_valid", u_dut.window_valid, 1'b0);
        check_flag("ofm_write_enable", ofm_write_enable, 1'b0);
        check_flag("start_to_next", start_to_next, 1'b0);
        check_flag("ofm_bank_sel", ofm_bank_sel, 1'b0);
        for (int run = 0; run < NUM_RUNS; run++)
            run_layer(run);
        if (exp_value.size() != 0 || pending_maps != 0)
            report_failure("output writes or hand-offs were still open after the last run");
        else
        begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+bench
hdl/conv_params_pkg.sv
hdl/conv_ctrl_pkg.sv
hdl/conv_control_unit.sv
hdl/window_feeder.sv
hdl/mac_unit.sv
hdl/psum_accumulator.sv
hdl/weight_bank.sv
hdl/conv_layer_top.sv
bench/conv_layer_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := conv_layer_tb
FILELIST   := files.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
